//--- ecc_mem.f
source/ecc_pkg.sv
source/wb_pkg.sv
source/secded_39_32_enc.sv
source/secded_39_32_dec.sv
source/wb_ecc_bridge.sv
source/ecc_sram.sv
source/ecc_mem_top.sv
test/tb_ecc_mem.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ecc_mem
FILELIST   := ecc_mem.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_ecc_mem.sv
// testbench for the ECC memory top level
// random Wishbone traffic with injected bit flips, checked against a shadow model

`timescale 1ns/1ps

module tb_ecc_mem;

  import ecc_pkg::*;
  import wb_pkg::*;

  localparam int unsigned AddrW = 6;
  localparam int unsigned Depth = 2 ** AddrW;
  localparam int Timeout = 20;  // cycles allowed per bus access

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  logic [AddrW-1:0]        wb_adr_i;
  wb_data_t                wb_dat_i;
  wb_data_t                wb_dat_o;
  logic                    wb_ack_o;
  logic                    wb_err_o;
  logic [EccCodeWidth-1:0] inject_mask_i;
  ecc_syndrome_t           syndrome_o;
  ecc_err_e                err_o;

  // reference model of the last written word and injected flips per address
  wb_data_t                shadow [Depth];
  logic [EccCodeWidth-1:0] flip_mask [Depth];

  integer seed;
  int     errors;
  int     checks;
  int     test_errs;
  int     tests_run;

  ecc_mem_top #(
    .MemAddrWidth ( AddrW )
  ) u_ecc_mem_top (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .wb_cyc_i      ( wb_cyc_i      ),
    .wb_stb_i      ( wb_stb_i      ),
    .wb_we_i       ( wb_we_i       ),
    .wb_adr_i      ( wb_adr_i      ),
    .wb_dat_i      ( wb_dat_i      ),
    .wb_dat_o      ( wb_dat_o      ),
    .wb_ack_o      ( wb_ack_o      ),
    .wb_err_o      ( wb_err_o      ),
    .inject_mask_i ( inject_mask_i ),
    .syndrome_o    ( syndrome_o    ),
    .err_o         ( err_o         )
  );

  always #10 clk_i = ~clk_i;

  function automatic int count_ones(input logic [63:0] v);
    int c;
    c = 0;
    for (int i = 0; i < 64; i++) begin
      if (v[i]) c++;
    end
    return c;
  endfunction

  // error class follows from the number of flipped bits alone
  function automatic logic [1:0] expected_class(input int flips);
    if (flips == 0) return 2'b00;
    else if (flips == 1) return 2'b01;
    else return 2'b10;
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("Simulation stopped at %0t ns: %s", $time, why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %-18s %s (%0d errors)", name, (test_errs == 0) ? "passed" : "failed",
             test_errs);
    test_errs = 0;
  endtask

  // one classic cycle that returns at a falling edge once the status registers settled
  task automatic bus_cycle(input logic we, input logic [AddrW-1:0] adr, input wb_data_t wdata,
                           input logic [EccCodeWidth-1:0] mask, output wb_data_t rdata,
                           output logic ack, output logic err);
    int n;
    @(posedge clk_i);
    wb_cyc_i      <= 1'b1;
    wb_stb_i      <= 1'b1;
    wb_we_i       <= we;
    wb_adr_i      <= adr;
    wb_dat_i      <= wdata;
    inject_mask_i <= mask;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(wb_ack_o || wb_err_o) && n < Timeout);
    if (!(wb_ack_o || wb_err_o)) begin
      abort_run("no ack or err from the memory within the timeout");
    end else begin
      check_eq(64'(n), 64'd2, "termination one cycle after stb sampled");
      ack   = wb_ack_o;
      err   = wb_err_o;
      rdata = wb_dat_o;
      @(posedge clk_i);
      wb_cyc_i      <= 1'b0;
      wb_stb_i      <= 1'b0;
      wb_we_i       <= 1'b0;
      inject_mask_i <= '0;
      @(negedge clk_i);
    end
  endtask

  task automatic write_word(input logic [AddrW-1:0] adr, input wb_data_t data,
                            input logic [EccCodeWidth-1:0] mask);
    wb_data_t rdata;
    logic     ack;
    logic     err;
    bus_cycle(1'b1, adr, data, mask, rdata, ack, err);
    check_eq(64'(ack), 64'd1, "write ack");
    check_eq(64'(err), 64'd0, "write err");
    shadow[adr]    = data;
    flip_mask[adr] = mask;
  endtask

  task automatic read_check(input logic [AddrW-1:0] adr);
    wb_data_t   rdata;
    logic       ack;
    logic       err;
    int         flips;
    logic [1:0] cls;
    flips = count_ones(64'(flip_mask[adr]));
    cls   = expected_class(flips);
    bus_cycle(1'b0, adr, '0, '0, rdata, ack, err);
    check_eq(64'(ack), 64'(flips < 2), "read ack");
    check_eq(64'(err), 64'(flips >= 2), "read err");
    if (flips < 2) check_eq(64'(rdata), 64'(shadow[adr]), "read data");
    check_eq(64'(err_o), 64'(cls), "error class");
    if (flips == 0) begin
      check_eq(64'(syndrome_o), 64'd0, "clean syndrome");
    end else begin
      check_eq(64'(syndrome_o != '0), 64'd1, "syndrome nonzero");
      check_eq(64'(count_ones(64'(syndrome_o)) % 2), 64'(flips % 2), "syndrome weight parity");
    end
  endtask

  task automatic double_mask(output logic [EccCodeWidth-1:0] mask);
    int a;
    int b;
    a = int'($unsigned($random(seed)) % EccCodeWidth);
    do begin
      b = int'($unsigned($random(seed)) % EccCodeWidth);
    end while (b == a);  // two distinct positions
    mask    = '0;
    mask[a] = 1'b1;
    mask[b] = 1'b1;
  endtask

  task automatic reset_test();
    check_eq(64'(wb_ack_o), 64'd0, "ack after reset");
    check_eq(64'(wb_err_o), 64'd0, "err after reset");
    check_eq(64'(syndrome_o), 64'd0, "syndrome after reset");
    check_eq(64'(err_o), 64'd0, "class after reset");
    end_test("reset");
  endtask

  task automatic clean_round_trip();
    logic [AddrW-1:0] adrs [64];
    for (int i = 0; i < 64; i++) begin
      adrs[i] = AddrW'($unsigned($random(seed)));
      write_word(adrs[i], $random(seed), '0);
    end
    for (int i = 0; i < 64; i++) begin
      read_check(adrs[i]);
    end
    end_test("clean round trip");
  endtask

  task automatic single_flip_test();
    logic [AddrW-1:0]        adr;
    logic [EccCodeWidth-1:0] mask;
    int                      pos;
    for (int i = 0; i < 16; i++) begin
      adr = AddrW'($unsigned($random(seed)));
      // alternate between the data field and the check field
      if (i % 2 == 0) pos = int'($unsigned($random(seed)) % EccDataWidth);
      else pos = EccDataWidth + int'($unsigned($random(seed)) % EccCheckWidth);
      mask      = '0;
      mask[pos] = 1'b1;
      write_word(adr, $random(seed), mask);
      read_check(adr);
    end
    end_test("single flip");
  endtask

  task automatic double_flip_test();
    logic [AddrW-1:0]        adr;
    logic [EccCodeWidth-1:0] mask;
    for (int i = 0; i < 16; i++) begin
      adr = AddrW'($unsigned($random(seed)));
      double_mask(mask);
      write_word(adr, $random(seed), mask);
      read_check(adr);
    end
    end_test("double flip");
  endtask

  task automatic status_hold_test();
    logic [AddrW-1:0]        adr;
    logic [EccCodeWidth-1:0] mask;
    ecc_syndrome_t           syn;
    logic [1:0]              cls;
    adr = AddrW'($unsigned($random(seed)));
    double_mask(mask);
    write_word(adr, $random(seed), mask);
    read_check(adr);
    syn = syndrome_o;
    cls = expected_class(count_ones(64'(mask)));
    for (int i = 0; i < 8; i++) begin
      adr = AddrW'($unsigned($random(seed)));
      write_word(adr, $random(seed), '0);
      check_eq(64'(syndrome_o), 64'(syn), "syndrome held over write");
      check_eq(64'(err_o), 64'(cls), "class held over write");
    end
    read_check(adr);  // clean read updates the status again
    end_test("status hold");
  endtask

  initial begin
    seed          = 32'hbca4_cb10;
    errors        = 0;
    checks        = 0;
    test_errs     = 0;
    tests_run     = 0;
    clk_i         = 1'b0;
    rst_n_i       <= 1'b0;
    wb_cyc_i      <= 1'b0;
    wb_stb_i      <= 1'b0;
    wb_we_i       <= 1'b0;
    wb_adr_i      <= '0;
    wb_dat_i      <= '0;
    inject_mask_i <= '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    reset_test();
    clean_round_trip();
    single_flip_test();
    double_flip_test();
    status_hold_test();
    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/ecc_mem_top.sv
// ECC memory top level
// Wishbone ECC bridge in front of the codeword memory

`timescale 1ns/1ps

module ecc_mem_top #(
  parameter int unsigned MemAddrWidth = 6
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [MemAddrWidth-1:0]          wb_adr_i,
  input  wb_pkg::wb_data_t                 wb_dat_i,
  output wb_pkg::wb_data_t                 wb_dat_o,
  output logic                             wb_ack_o,
  output logic                             wb_err_o,
  input  logic [ecc_pkg::EccCodeWidth-1:0] inject_mask_i,
  output ecc_pkg::ecc_syndrome_t           syndrome_o,
  output ecc_pkg::ecc_err_e                err_o
);

  import ecc_pkg::*;

  logic                    mem_cyc;
  logic                    mem_stb;
  logic                    mem_we;
  logic [MemAddrWidth-1:0] mem_adr;
  ecc_code_u               wr_code;
  ecc_code_u               rd_code;
  logic                    mem_ack;

  wb_ecc_bridge #(
    .MemAddrWidth ( MemAddrWidth )
  ) u_bridge (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .wb_cyc_i   ( wb_cyc_i   ),
    .wb_stb_i   ( wb_stb_i   ),
    .wb_we_i    ( wb_we_i    ),
    .wb_adr_i   ( wb_adr_i   ),
    .wb_dat_i   ( wb_dat_i   ),
    .wb_dat_o   ( wb_dat_o   ),
    .wb_ack_o   ( wb_ack_o   ),
    .wb_err_o   ( wb_err_o   ),
    .mem_cyc_o  ( mem_cyc    ),
    .mem_stb_o  ( mem_stb    ),
    .mem_we_o   ( mem_we     ),
    .mem_adr_o  ( mem_adr    ),
    .mem_code_o ( wr_code    ),
    .mem_code_i ( rd_code    ),
    .mem_ack_i  ( mem_ack    ),
    .syndrome_o ( syndrome_o ),
    .err_o      ( err_o      )
  );

  ecc_sram #(
    .MemAddrWidth ( MemAddrWidth )
  ) u_sram (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cyc_i         ( mem_cyc       ),
    .stb_i         ( mem_stb       ),
    .we_i          ( mem_we        ),
    .adr_i         ( mem_adr       ),
    .code_i        ( wr_code       ),
    .inject_mask_i ( inject_mask_i ),
    .code_o        ( rd_code       ),
    .ack_o         ( mem_ack       )
  );

endmodule

//--- source/ecc_sram.sv
// Wishbone classic codeword memory
// one-cycle acknowledge, fault-injection mask XORed into every write

`timescale 1ns/1ps

module ecc_sram #(
  parameter int unsigned MemAddrWidth = 6
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             cyc_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [MemAddrWidth-1:0]          adr_i,
  input  ecc_pkg::ecc_code_u               code_i,
  input  logic [ecc_pkg::EccCodeWidth-1:0] inject_mask_i,
  output ecc_pkg::ecc_code_u               code_o,
  output logic                             ack_o
);

  import ecc_pkg::*;

  localparam int unsigned Depth = 2 ** MemAddrWidth;

  ecc_code_u mem_q [Depth];
  logic      req;

  // new request only while no ack is pending
  assign req = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;  // single-cycle pulse
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we_i) begin
        mem_q[adr_i].bits <= code_i.bits ^ inject_mask_i;  // stored error pattern
      end else begin
        code_o <= mem_q[adr_i];  // valid together with ack
      end
    end
  end

endmodule

//--- source/wb_ecc_bridge.sv
// Wishbone ECC bridge
// encodes write words into codewords, decodes and corrects read codewords,
// and ends reads with an uncorrectable error as an error cycle

`timescale 1ns/1ps

module wb_ecc_bridge #(
  parameter int unsigned MemAddrWidth = 6
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // slave port from the bus master
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [MemAddrWidth-1:0] wb_adr_i,
  input  wb_pkg::wb_data_t       wb_dat_i,
  output wb_pkg::wb_data_t       wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  // master port to the codeword memory
  output logic                   mem_cyc_o,
  output logic                   mem_stb_o,
  output logic                   mem_we_o,
  output logic [MemAddrWidth-1:0] mem_adr_o,
  output ecc_pkg::ecc_code_u     mem_code_o,
  input  ecc_pkg::ecc_code_u     mem_code_i,
  input  logic                   mem_ack_i,
  // status of the last read
  output ecc_pkg::ecc_syndrome_t syndrome_o,
  output ecc_pkg::ecc_err_e      err_o
);

  import ecc_pkg::*;

  ecc_syndrome_t dec_syndrome;
  ecc_err_e      dec_err;
  logic          rd_done;
  logic          rd_fail;

  // request path goes straight through
  assign mem_cyc_o = wb_cyc_i;
  assign mem_stb_o = wb_stb_i;
  assign mem_we_o  = wb_we_i;
  assign mem_adr_o = wb_adr_i;

  secded_39_32_enc u_enc (
    .data_i ( wb_dat_i   ),
    .code_o ( mem_code_o )
  );

  secded_39_32_dec u_dec (
    .code_i     ( mem_code_i   ),
    .data_o     ( wb_dat_o     ),
    .syndrome_o ( dec_syndrome ),
    .err_o      ( dec_err      )
  );

  assign rd_done = mem_ack_i & ~wb_we_i;
  assign rd_fail = rd_done & (dec_err == EccErrUncorrectable);

  // err replaces ack when the read word cannot be trusted
  assign wb_ack_o = mem_ack_i & ~rd_fail;
  assign wb_err_o = rd_fail;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      syndrome_o <= '0;
      err_o      <= EccErrNone;
    end else if (rd_done) begin  // writes leave the status alone
      syndrome_o <= dec_syndrome;
      err_o      <= dec_err;
    end
  end

endmodule

//--- source/secded_39_32_dec.sv
// SECDED (39,32) decoder
// syndrome, single-bit correction and error classification

`timescale 1ns/1ps

module secded_39_32_dec (
  input  ecc_pkg::ecc_code_u               code_i,
  output logic [ecc_pkg::EccDataWidth-1:0] data_o,
  output ecc_pkg::ecc_syndrome_t           syndrome_o,
  output ecc_pkg::ecc_err_e                err_o
);

  import ecc_pkg::*;

  ecc_syndrome_t           syndrome;
  logic [EccCodeWidth-1:0] flip;
  ecc_code_u               fixed;

  always_comb begin
    for (int i = 0; i < EccCheckWidth; i++) begin
      syndrome[i] = ^(code_i.bits & EccCheckMask[i]);
    end
  end

  // flag the codeword bit whose matrix column equals the syndrome
  // all columns have odd weight, so zero and even syndromes select nothing
  always_comb begin
    ecc_syndrome_t column;
    flip = '0;
    for (int b = 0; b < EccCodeWidth; b++) begin
      for (int i = 0; i < EccCheckWidth; i++) begin
        column[i] = EccCheckMask[i][b];
      end
      flip[b] = (column == syndrome);
    end
  end

  assign fixed.bits = code_i.bits ^ flip;
  assign data_o     = fixed.fields.data;  // unchanged on a double flip
  assign syndrome_o = syndrome;

  always_comb begin
    if (syndrome == '0) begin
      err_o = EccErrNone;
    end else if (^syndrome) begin
      err_o = EccErrCorrected;      // odd weight
    end else begin
      err_o = EccErrUncorrectable;  // nonzero even weight
    end
  end

endmodule

//--- source/secded_39_32_enc.sv
// SECDED (39,32) encoder
// computes the 7 check bits of a data word and packs the codeword

`timescale 1ns/1ps

module secded_39_32_enc (
  input  logic [ecc_pkg::EccDataWidth-1:0] data_i,
  output ecc_pkg::ecc_code_u               code_o
);

  import ecc_pkg::*;

  logic [EccCheckWidth-1:0] check;

  // each check bit covers the data bits of its row, so the full syndrome is zero
  always_comb begin
    for (int i = 0; i < EccCheckWidth; i++) begin
      check[i] = ^(data_i & EccCheckMask[i][EccDataWidth-1:0]);
    end
  end

  assign code_o.fields = '{check: check, data: data_i};

endmodule

//--- source/wb_pkg.sv
// Wishbone bus word definitions

package wb_pkg;

  localparam int unsigned WbDataWidth = 32;

  typedef logic [WbDataWidth-1:0] wb_data_t;

endpackage

//--- source/ecc_pkg.sv
// SECDED (39,32) code definitions
// Hsiao odd-weight-column parity masks, codeword layout and error classes

package ecc_pkg;

  localparam int unsigned EccDataWidth  = 32;
  localparam int unsigned EccCheckWidth = 7;
  localparam int unsigned EccCodeWidth  = EccDataWidth + EccCheckWidth;

  // check field sits above the data field
  typedef struct packed {
    logic [EccCheckWidth-1:0] check;
    logic [EccDataWidth-1:0]  data;
  } ecc_code_fields_t;

  typedef union packed {
    logic [EccCodeWidth-1:0] bits;    // flat view for syndrome and flip masks
    ecc_code_fields_t        fields;
  } ecc_code_u;

  typedef logic [EccCheckWidth-1:0] ecc_syndrome_t;

  typedef enum logic [1:0] {
    EccErrNone          = 2'b00,
    EccErrCorrected     = 2'b01,  // single flip fixed
    EccErrUncorrectable = 2'b10   // double flip seen
  } ecc_err_e;

  // row i of the parity check matrix
  // data columns are 32 distinct weight-3 vectors, check columns are weight 1
  localparam logic [EccCodeWidth-1:0] EccCheckMask [EccCheckWidth] = '{
    39'h01_0000_7fff,
    39'h02_01ff_801f,
    39'h04_7e07_81e1,
    39'h08_8e38_8e22,
    39'h10_b2c9_3244,
    39'h20_d552_5488,
    39'h40_69a4_6910
  };

endpackage
